//--- design/fpAddSubPkg.sv
`default_nettype none

package fpAddSubPkg;

	// Half-precision layout
	localparam int expWidth  = 5;
	localparam int manWidth  = 10;
	localparam int dataWidth = 16;

	// Hidden bit, fraction, then guard, round and sticky
	localparam int extWidth  = 14;

	localparam logic [expWidth-1:0] expMax = 5'd31; // Inf and NaN exponent

	typedef enum logic {
		opAdd = 1'b0,
		opSub = 1'b1
	} fpOp;

	// Special encodings
	localparam logic [dataWidth-1:0] qNaN   = 16'h7E00;
	localparam logic [dataWidth-1:0] posInf = 16'h7C00;
	localparam logic [dataWidth-1:0] negInf = 16'hFC00;

endpackage

`default_nettype wire

//--- design/fpAddSubPrealign.sv
`timescale 1ns/1ps
`default_nettype none

module fpAddSubPrealign (
	input  logic [fpAddSubPkg::dataWidth-1:0]  a,
	input  logic [fpAddSubPkg::dataWidth-1:0]  b,
	input  fpAddSubPkg::fpOp                   op,
	output logic [2*fpAddSubPkg::expWidth-1:0] shiftDet, // {expB-expA, expA-expB}
	output logic                               specialValid,
	output logic [fpAddSubPkg::dataWidth-1:0]  specialValue
);

	logic [fpAddSubPkg::expWidth-1:0] expA, expB;
	logic [fpAddSubPkg::manWidth-1:0] manA, manB;
	logic signA, effSignB;
	logic nanA, nanB, infA, infB, zeroA, zeroB;

	assign expA = a[fpAddSubPkg::dataWidth-2:fpAddSubPkg::manWidth];
	assign expB = b[fpAddSubPkg::dataWidth-2:fpAddSubPkg::manWidth];
	assign manA = a[fpAddSubPkg::manWidth-1:0];
	assign manB = b[fpAddSubPkg::manWidth-1:0];
	assign signA = a[fpAddSubPkg::dataWidth-1];
	assign effSignB = b[fpAddSubPkg::dataWidth-1] ^ (op == fpAddSubPkg::opSub); // Sub flips b

	// Both differences wrap, align picks the non-negative one
	assign shiftDet = {expB - expA, expA - expB};

	// Classification, subnormals count as zero
	assign nanA  = (expA == fpAddSubPkg::expMax) && (manA != '0);
	assign nanB  = (expB == fpAddSubPkg::expMax) && (manB != '0);
	assign infA  = (expA == fpAddSubPkg::expMax) && (manA == '0);
	assign infB  = (expB == fpAddSubPkg::expMax) && (manB == '0);
	assign zeroA = (expA == '0);
	assign zeroB = (expB == '0);

	always_comb begin
		specialValid = 1'b1;
		specialValue = fpAddSubPkg::qNaN;
		if (nanA || nanB) begin
			specialValue = fpAddSubPkg::qNaN;
		end else if (infA && infB) begin
			// Opposite effective signs cancel into NaN
			if (signA != effSignB) specialValue = fpAddSubPkg::qNaN;
			else specialValue = signA ? fpAddSubPkg::negInf : fpAddSubPkg::posInf;
		end else if (infA) begin
			specialValue = signA ? fpAddSubPkg::negInf : fpAddSubPkg::posInf;
		end else if (infB) begin
			specialValue = effSignB ? fpAddSubPkg::negInf : fpAddSubPkg::posInf;
		end else if (zeroA && zeroB) begin
			specialValue = {signA & effSignB, {(fpAddSubPkg::dataWidth-1){1'b0}}}; // -0 only if both negative
		end else begin
			specialValid = 1'b0; // Ordinary operands go through the datapath
		end
	end

endmodule

`default_nettype wire

//--- design/fpAddSubAlign.sv
`timescale 1ns/1ps
`default_nettype none

module fpAddSubAlign (
	input  logic [fpAddSubPkg::dataWidth-2:0]  a,        // Magnitude only
	input  logic [fpAddSubPkg::dataWidth-2:0]  b,
	input  logic [2*fpAddSubPkg::expWidth-1:0] shiftDet,
	output logic [fpAddSubPkg::expWidth-1:0]   cExp,     // Common exponent
	output logic                               maxAb,    // 1 when b is larger
	output logic [fpAddSubPkg::expWidth-1:0]   shift,    // Right shift for the smaller mantissa
	output logic [fpAddSubPkg::manWidth-1:0]   mMin,
	output logic [fpAddSubPkg::manWidth-1:0]   mMax
);

	// Exponent sits above fraction, so integer compare orders magnitudes
	assign maxAb = (a < b);

	// Non-negative half of the difference pair
	assign shift = maxAb ? shiftDet[2*fpAddSubPkg::expWidth-1:fpAddSubPkg::expWidth]
		: shiftDet[fpAddSubPkg::expWidth-1:0];

	assign mMin = maxAb ? a[fpAddSubPkg::manWidth-1:0] : b[fpAddSubPkg::manWidth-1:0];
	assign mMax = maxAb ? b[fpAddSubPkg::manWidth-1:0] : a[fpAddSubPkg::manWidth-1:0];

	// Larger operand sets the exponent
	assign cExp = maxAb ? b[fpAddSubPkg::dataWidth-2:fpAddSubPkg::manWidth]
		: a[fpAddSubPkg::dataWidth-2:fpAddSubPkg::manWidth];

endmodule

`default_nettype wire

//--- design/fpAddSubShift.sv
`timescale 1ns/1ps
`default_nettype none

module fpAddSubShift (
	input  logic [fpAddSubPkg::manWidth-1:0] mMin,
	input  logic [fpAddSubPkg::manWidth-1:0] mMax,
	input  logic [fpAddSubPkg::expWidth-1:0] shift,
	input  logic                             minZero,    // Smaller operand has zero exponent
	input  logic                             maxZero,
	output logic [fpAddSubPkg::extWidth-1:0] alignedMin,
	output logic [fpAddSubPkg::extWidth-1:0] alignedMax
);

	logic [fpAddSubPkg::extWidth-1:0]   extMin, extMax;
	logic [2*fpAddSubPkg::extWidth-1:0] wide;          // Room below for bits shifted out
	logic                               lostBits;

	// Hidden bit, fraction, three empty guard positions
	// A zero exponent drops the whole mantissa, so subnormals act as zero
	assign extMin = minZero ? '0 : {1'b1, mMin, 3'b000};
	assign extMax = maxZero ? '0 : {1'b1, mMax, 3'b000};

	assign alignedMax = extMax; // Larger operand never moves

	assign wide = {extMin, {fpAddSubPkg::extWidth{1'b0}}} >> shift;
	assign lostBits = |wide[fpAddSubPkg::extWidth-1:0];

	always_comb begin
		if (shift >= fpAddSubPkg::expWidth'(fpAddSubPkg::extWidth)) begin
			// Everything falls past the sticky position
			alignedMin = {{(fpAddSubPkg::extWidth-1){1'b0}}, |extMin};
		end else begin
			alignedMin = {wide[2*fpAddSubPkg::extWidth-1:fpAddSubPkg::extWidth+1],
				wide[fpAddSubPkg::extWidth] | lostBits};     // Sticky collects shifted-out ones
		end
	end

endmodule

`default_nettype wire

//--- design/fpAddSubExecute.sv
`timescale 1ns/1ps
`default_nettype none

module fpAddSubExecute (
	input  logic [fpAddSubPkg::extWidth-1:0] alignedMin,
	input  logic [fpAddSubPkg::extWidth-1:0] alignedMax,
	input  logic [fpAddSubPkg::expWidth-1:0] cExp,
	input  logic                             maxAb,
	input  logic                             signA,
	input  logic                             signB,
	input  fpAddSubPkg::fpOp                 op,
	output logic [fpAddSubPkg::extWidth:0]   sum,        // Top bit is the carry
	output logic                             resultSign,
	output logic [fpAddSubPkg::expWidth-1:0] exponent,
	output logic                             isZero
);

	logic isSub;
	logic effSub;
	logic effSignB;

	assign isSub = (op == fpAddSubPkg::opSub);
	assign effSignB = signB ^ isSub;

	// Differing effective signs mean magnitude subtraction
	assign effSub = signA ^ signB ^ isSub;

	always_comb begin
		if (effSub) begin
			// Larger minus smaller, never negative
			sum = {1'b0, alignedMax} - {1'b0, alignedMin};
		end else begin
			sum = {1'b0, alignedMax} + {1'b0, alignedMin};
		end
	end

	assign resultSign = maxAb ? effSignB : signA; // Sign of the larger magnitude
	assign exponent = cExp;
	assign isZero = (sum == '0); // Exact cancellation, packed as +0

endmodule

`default_nettype wire

//--- design/fpAddSubNormalize.sv
`timescale 1ns/1ps
`default_nettype none

module fpAddSubNormalize (
	input  logic [fpAddSubPkg::extWidth:0]   sum,
	input  logic [fpAddSubPkg::expWidth-1:0] exponent,
	input  logic                             isZero,
	output logic [fpAddSubPkg::extWidth-1:0] normMan,   // Hidden bit at the top
	output logic [fpAddSubPkg::expWidth:0]   normExp,   // One spare bit for under and overflow
	output logic                             flushZero
);

	logic       carry;
	logic [3:0] lz;              // Leading zeros below the carry bit
	logic [fpAddSubPkg::extWidth-1:0] leftMan;
	logic [fpAddSubPkg::expWidth:0]   leftExp;
	logic [fpAddSubPkg::expWidth:0]   rightExp;

	assign carry = sum[fpAddSubPkg::extWidth];

	// Highest set bit wins since the loop runs upward
	always_comb begin
		lz = '0;
		for (int i = 0; i < fpAddSubPkg::extWidth; i++) begin
			if (sum[i]) lz = 4'(fpAddSubPkg::extWidth - 1 - i);
		end
	end

	assign leftMan = sum[fpAddSubPkg::extWidth-1:0] << lz;
	assign leftExp = {1'b0, exponent} - {2'b00, lz};
	assign rightExp = {1'b0, exponent} + 1'b1;

	always_comb begin
		if (carry) begin
			// One step right, dropped bit stays in sticky
			normMan = {sum[fpAddSubPkg::extWidth:2], sum[1] | sum[0]};
			normExp = rightExp;
		end else begin
			normMan = leftMan;
			normExp = leftExp;
		end
	end

	// Zero or negative exponent flushes, sign bit of normExp marks negative
	// An exact zero sum goes the same way
	assign flushZero = isZero || normExp[fpAddSubPkg::expWidth] || (normExp == '0);

endmodule

`default_nettype wire

//--- design/fpAddSubRound.sv
`timescale 1ns/1ps
`default_nettype none

module fpAddSubRound (
	input  logic [fpAddSubPkg::extWidth-1:0]  normMan,
	input  logic [fpAddSubPkg::expWidth:0]    normExp,
	input  logic                              resultSign,
	input  logic                              flushZero,
	input  logic                              specialValid,
	input  logic [fpAddSubPkg::dataWidth-1:0] specialValue,
	output logic [fpAddSubPkg::dataWidth-1:0] result
);

	logic guardBit, roundBit, stickyBit, lsb;
	logic roundUp;
	logic [fpAddSubPkg::manWidth+1:0] rounded;   // Carry, hidden bit, fraction
	logic                             roundCarry;
	logic [fpAddSubPkg::expWidth:0]   finalExp;
	logic [fpAddSubPkg::manWidth-1:0] finalMan;
	logic                             overflow;

	assign guardBit  = normMan[2];
	assign roundBit  = normMan[1];
	assign stickyBit = normMan[0];
	assign lsb       = normMan[3];

	// Nearest even, exact ties go to an even LSB
	assign roundUp = guardBit & (roundBit | stickyBit | lsb);

	assign rounded = {1'b0, normMan[fpAddSubPkg::extWidth-1:3]} + roundUp;
	assign roundCarry = rounded[fpAddSubPkg::manWidth+1];

	// Rounding carry leaves 1.000 with a zero fraction
	assign finalMan = rounded[fpAddSubPkg::manWidth-1:0];
	assign finalExp = normExp + roundCarry;

	// Unsigned test, flush cases never get here
	assign overflow = (finalExp >= {1'b0, fpAddSubPkg::expMax});

	always_comb begin
		if (specialValid) begin
			result = specialValue; // NaN, infinity and zero bypass
		end else if (flushZero) begin
			result = '0;
		end else if (overflow) begin
			result = resultSign ? fpAddSubPkg::negInf : fpAddSubPkg::posInf;
		end else begin
			result = {resultSign, finalExp[fpAddSubPkg::expWidth-1:0], finalMan};
		end
	end

endmodule

`default_nettype wire

//--- design/fpAddSub.sv
`timescale 1ns/1ps
`default_nettype none

module fpAddSub (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              inValid,
	input  logic [fpAddSubPkg::dataWidth-1:0] a,
	input  logic [fpAddSubPkg::dataWidth-1:0] b,
	input  fpAddSubPkg::fpOp                  op,
	output logic                              outValid,
	output logic [fpAddSubPkg::dataWidth-1:0] result
);

	localparam int ew = fpAddSubPkg::expWidth;
	localparam int mw = fpAddSubPkg::manWidth;
	localparam int dw = fpAddSubPkg::dataWidth;
	localparam int xw = fpAddSubPkg::extWidth;

	// Stage 0
	logic [2*ew-1:0] shiftDet;
	logic            specialValid0;
	logic [dw-1:0]   specialValue0;
	logic [ew-1:0]   cExp0, shift0;
	logic            maxAb0;
	logic [mw-1:0]   mMin0, mMax0;

	// Rank 1
	logic              valid1;
	logic [ew-1:0]     cExp1, shift1;
	logic              maxAb1, signA1, signB1, zeroA1, zeroB1;
	logic [mw-1:0]     mMin1, mMax1;
	fpAddSubPkg::fpOp  op1;
	logic              specialValid1;
	logic [dw-1:0]     specialValue1;

	// Stage 1
	logic [xw-1:0] alignedMin, alignedMax;
	logic [xw:0]   sum1;
	logic          resultSign1, isZero1;
	logic [ew-1:0] exponent1;

	// Rank 2
	logic          valid2;
	logic [xw:0]   sum2;
	logic          resultSign2, isZero2;
	logic [ew-1:0] exponent2;
	logic          specialValid2;
	logic [dw-1:0] specialValue2;

	// Stage 2
	logic [xw-1:0] normMan;
	logic [ew:0]   normExp;
	logic          flushZero;
	logic [dw-1:0] result2;

	fpAddSubPrealign prealign_inst (
		.a(a), .b(b), .op(op),
		.shiftDet(shiftDet), .specialValid(specialValid0), .specialValue(specialValue0)
	);

	fpAddSubAlign align_inst (
		.a(a[dw-2:0]), .b(b[dw-2:0]), .shiftDet(shiftDet),
		.cExp(cExp0), .maxAb(maxAb0), .shift(shift0), .mMin(mMin0), .mMax(mMax0)
	);

	// Valid ranks only, the payload runs free
	always_ff @(posedge clk) begin
		if (reset) begin
			valid1   <= 1'b0;
			valid2   <= 1'b0;
			outValid <= 1'b0;
		end else begin
			valid1   <= inValid;
			valid2   <= valid1;
			outValid <= valid2;
		end
	end

	always_ff @(posedge clk) begin
		cExp1         <= cExp0;
		maxAb1        <= maxAb0;
		shift1        <= shift0;
		mMin1         <= mMin0;
		mMax1         <= mMax0;
		signA1        <= a[dw-1];
		signB1        <= b[dw-1];
		zeroA1        <= (a[dw-2:mw] == '0); // Zero exponent, subnormal included
		zeroB1        <= (b[dw-2:mw] == '0);
		op1           <= op;
		specialValid1 <= specialValid0;
		specialValue1 <= specialValue0;
	end

	fpAddSubShift shift_inst (
		.mMin(mMin1), .mMax(mMax1), .shift(shift1),
		.minZero(maxAb1 ? zeroA1 : zeroB1), // Zero flags follow the swap
		.maxZero(maxAb1 ? zeroB1 : zeroA1),
		.alignedMin(alignedMin), .alignedMax(alignedMax)
	);

	fpAddSubExecute execute_inst (
		.alignedMin(alignedMin), .alignedMax(alignedMax), .cExp(cExp1),
		.maxAb(maxAb1), .signA(signA1), .signB(signB1), .op(op1),
		.sum(sum1), .resultSign(resultSign1), .exponent(exponent1), .isZero(isZero1)
	);

	always_ff @(posedge clk) begin
		sum2          <= sum1;
		resultSign2   <= resultSign1;
		exponent2     <= exponent1;
		isZero2       <= isZero1;
		specialValid2 <= specialValid1;
		specialValue2 <= specialValue1;
	end

	fpAddSubNormalize normalize_inst (
		.sum(sum2), .exponent(exponent2), .isZero(isZero2),
		.normMan(normMan), .normExp(normExp), .flushZero(flushZero)
	);

	fpAddSubRound round_inst (
		.normMan(normMan), .normExp(normExp), .resultSign(resultSign2),
		.flushZero(flushZero), .specialValid(specialValid2),
		.specialValue(specialValue2), .result(result2)
	);

	always_ff @(posedge clk) begin
		result <= result2; // Output rank
	end

endmodule

`default_nettype wire

//--- verification/fpAddSubTb.sv
`timescale 1ns/1ps
`default_nettype none

module fpAddSubTb;

	localparam int randomOps   = 2000;
	localparam int gapCycles   = 300;                    // Upper bound on gapped issues
	localparam int directedOps = 12 + 8 + 16 + 6 + 7;    // Normal, cancel, special, overflow, reset
	localparam int cycleLimit  = 2 * (directedOps + randomOps + gapCycles) + 100;

	logic             clk;
	logic             reset;
	logic             inValid;
	logic [15:0]      a;
	logic [15:0]      b;
	fpAddSubPkg::fpOp op;
	logic             outValid;
	logic [15:0]      result;

	logic [15:0] lfsrState;
	int          cycleCount = 0;
	int          passCount = 0;
	int          failCount = 0;
	int          testChecks = 0;
	int          testFails = 0;
	logic [15:0] expectQ[$];
	int          dueQ[$];         // Cycle at which each result must show up

	fpAddSub fpAddSub_inst (
		.clk(clk), .reset(reset), .inValid(inValid), .a(a), .b(b), .op(op),
		.outValid(outValid), .result(result)
	);

	always #10 clk = ~clk; // 20 ns period

	// x^16 + x^14 + x^13 + x^11 + 1, shifting right
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return {s[0] ^ s[2] ^ s[3] ^ s[5], s[15:1]};
	endfunction

	task automatic takeBits(input int n, output logic [15:0] value);
		value = '0;
		for (int i = 0; i < n; i++) begin
			value = {value[14:0], lfsrState[0]}; // One step per bit
			lfsrState = lfsrNext(lfsrState);
		end
	endtask

	// Exact sum on integers scaled by 2^24, then normalize and round
	function automatic logic [15:0] fpAddSubModel(input logic [15:0] x, input logic [15:0] y,
			input fpAddSubPkg::fpOp code);
		logic       sx, sy, signOut, roundUp;
		logic [4:0] ex, ey;
		logic [9:0] fx, fy;
		longint     vx, vy, total, mag, kept, rest, half;
		int         msb, shiftDown, expOut;
		sx = x[15];
		sy = y[15] ^ (code == fpAddSubPkg::opSub); // Effective sign of b
		ex = x[14:10];
		ey = y[14:10];
		fx = x[9:0];
		fy = y[9:0];
		if ((ex == 5'd31 && fx != 0) || (ey == 5'd31 && fy != 0)) return fpAddSubPkg::qNaN;
		if (ex == 5'd31 && ey == 5'd31) return (sx != sy) ? fpAddSubPkg::qNaN : {sx, 5'h1F, 10'h0};
		if (ex == 5'd31) return {sx, 5'h1F, 10'h0};
		if (ey == 5'd31) return {sy, 5'h1F, 10'h0};
		if (ex == 0 && ey == 0) return {sx & sy, 15'h0}; // Signed zero rule
		// Subnormals read as zero
		vx = (ex == 0) ? 0 : longint'({1'b1, fx}) << (ex - 1);
		vy = (ey == 0) ? 0 : longint'({1'b1, fy}) << (ey - 1);
		if (sx) vx = -vx;
		if (sy) vy = -vy;
		total = vx + vy;
		if (total == 0) return 16'h0000;
		signOut = (total < 0);
		mag = signOut ? -total : total;
		msb = 0;
		for (int i = 0; i < 48; i++) begin
			if (mag[i]) msb = i;
		end
		expOut = msb - 9;
		if (expOut <= 0) return 16'h0000; // Below normal range before rounding
		shiftDown = msb - 10;
		kept = mag >> shiftDown;
		rest = mag - (kept << shiftDown);
		roundUp = 1'b0;
		if (shiftDown > 0) begin
			half = longint'(1) << (shiftDown - 1);
			roundUp = (rest > half) || (rest == half && kept[0]); // Ties to even
		end
		kept = kept + roundUp;
		if (kept == 2048) begin
			kept = 1024;
			expOut++;
		end
		if (expOut >= 31) return {signOut, 5'h1F, 10'h0};
		return {signOut, 5'(expOut), kept[9:0]};
	endfunction

	task automatic checkValue(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		testChecks++;
		if (actual !== expected) begin
			$display("[FAIL] %s expected %h, got %h", name, expected, actual);
			failCount++;
			testFails++;
		end else begin
			passCount++;
		end
	endtask

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("Timeout: no finish within %0d cycles", cycleLimit);
			$display("Result: FAILED");
			$finish;
		end
	end

	// Falling edge keeps sampling clear of the register updates
	always @(negedge clk) begin
		if (outValid === 1'b1) begin
			if (expectQ.size() == 0) begin
				$display("outValid high at cycle %0d with no operation in flight", cycleCount);
				failCount++;
				testFails++;
			end else begin
				if (dueQ[0] != cycleCount) begin
					$display("Result came at cycle %0d but was due at cycle %0d",
						cycleCount, dueQ[0]);
					failCount++;
					testFails++;
				end
				checkValue("result", expectQ[0], result);
				expectQ.delete(0);
				dueQ.delete(0);
			end
		end
	end

	// Inputs change 2 ns after the rising edge
	task automatic driveCycle(input logic valid, input logic [15:0] x, input logic [15:0] y,
			input fpAddSubPkg::fpOp code);
		@(posedge clk);
		#2;
		inValid = valid;
		a = x;
		b = y;
		op = code;
		if (valid) begin
			expectQ.push_back(fpAddSubModel(x, y, code));
			dueQ.push_back(cycleCount + 3); // Three register ranks from drive to outValid
		end
	endtask

	task automatic issueOp(input logic [15:0] x, input logic [15:0] y,
			input fpAddSubPkg::fpOp code);
		driveCycle(1'b1, x, y, code);
	endtask

	task automatic issueRandom(input logic valid);
		logic [15:0] x, y, code;
		takeBits(16, x);
		takeBits(16, y);
		takeBits(1, code);
		driveCycle(valid, x, y, fpAddSubPkg::fpOp'(code[0]));
	endtask

	task automatic finishTest(input string name);
		driveCycle(1'b0, '0, '0, fpAddSubPkg::opAdd);
		while (expectQ.size() != 0) @(posedge clk); // Drain the pipeline
		$display("%s: %0d results checked, %0d errors", name, testChecks, testFails);
		testChecks = 0;
		testFails = 0;
	endtask

	initial begin
		logic [15:0] pick;
		clk = 1'b0;
		reset = 1'b1;
		inValid = 1'b0;
		a = '0;
		b = '0;
		op = fpAddSubPkg::opAdd;
		lfsrState = 16'd41;
		repeat (10) @(posedge clk);
		#2;
		reset = 1'b0;

		issueOp(16'h3C00, 16'h3C00, fpAddSubPkg::opAdd);
		issueOp(16'h3C00, 16'h3800, fpAddSubPkg::opSub);
		issueOp(16'h4200, 16'h3C00, fpAddSubPkg::opAdd);
		issueOp(16'h3E00, 16'h3D00, fpAddSubPkg::opAdd); // Equal exponents
		issueOp(16'h6000, 16'h1000, fpAddSubPkg::opAdd); // Gap past the sticky bit
		issueOp(16'h6000, 16'h1000, fpAddSubPkg::opSub);
		issueOp(16'h3C00, 16'h1000, fpAddSubPkg::opAdd); // Tie, stays even
		issueOp(16'h3C01, 16'h1000, fpAddSubPkg::opAdd); // Tie, rounds up to even
		issueOp(16'h4000, 16'h3C01, fpAddSubPkg::opSub);
		issueOp(16'h5BFF, 16'h3C00, fpAddSubPkg::opAdd);
		issueOp(16'hC500, 16'h4100, fpAddSubPkg::opAdd);
		issueOp(16'h4248, 16'h3A66, fpAddSubPkg::opSub);
		finishTest("normal");

		issueOp(16'h3C01, 16'h3C00, fpAddSubPkg::opSub);
		issueOp(16'h3C00, 16'h3BFF, fpAddSubPkg::opSub);
		issueOp(16'h3C00, 16'h3C00, fpAddSubPkg::opSub); // Exact zero
		issueOp(16'h0400, 16'h0401, fpAddSubPkg::opSub); // Underflow
		issueOp(16'h0800, 16'h07FF, fpAddSubPkg::opSub);
		issueOp(16'hC400, 16'h4400, fpAddSubPkg::opAdd);
		issueOp(16'h4B00, 16'h4AFF, fpAddSubPkg::opSub);
		issueOp(16'h5640, 16'hD63F, fpAddSubPkg::opAdd);
		finishTest("cancellation");

		issueOp(16'h7E00, 16'h3C00, fpAddSubPkg::opAdd);
		issueOp(16'h3C00, 16'h7D00, fpAddSubPkg::opSub);
		issueOp(16'hFE01, 16'h0000, fpAddSubPkg::opAdd);
		issueOp(16'h7C00, 16'h7C00, fpAddSubPkg::opSub);
		issueOp(16'h7C00, 16'hFC00, fpAddSubPkg::opAdd);
		issueOp(16'h7C00, 16'h7C00, fpAddSubPkg::opAdd);
		issueOp(16'hFC00, 16'h7C00, fpAddSubPkg::opSub);
		issueOp(16'h7C00, 16'h3C00, fpAddSubPkg::opAdd);
		issueOp(16'h3C00, 16'h7C00, fpAddSubPkg::opSub);
		issueOp(16'h8000, 16'h8000, fpAddSubPkg::opAdd);
		issueOp(16'h8000, 16'h0000, fpAddSubPkg::opSub);
		issueOp(16'h0000, 16'h0000, fpAddSubPkg::opSub);
		issueOp(16'h8000, 16'h0000, fpAddSubPkg::opAdd);
		issueOp(16'h0001, 16'h3C00, fpAddSubPkg::opAdd); // Subnormal reads as zero
		issueOp(16'h83FF, 16'h4000, fpAddSubPkg::opSub);
		issueOp(16'h0200, 16'h0100, fpAddSubPkg::opAdd);
		finishTest("specials");

		issueOp(16'h7BFF, 16'h7BFF, fpAddSubPkg::opAdd);
		issueOp(16'h7BFF, 16'h4C00, fpAddSubPkg::opAdd); // Half ulp at the top
		issueOp(16'h7BFF, 16'h4B00, fpAddSubPkg::opAdd);
		issueOp(16'hFBFF, 16'h7BFF, fpAddSubPkg::opSub);
		issueOp(16'h7800, 16'h7800, fpAddSubPkg::opAdd);
		issueOp(16'hFBFF, 16'hCC00, fpAddSubPkg::opAdd);
		finishTest("overflow");

		repeat (randomOps) issueRandom(1'b1);
		finishTest("random");

		for (int i = 0; i < gapCycles; i++) begin
			takeBits(1, pick);
			issueRandom(pick[0]);
		end
		finishTest("gapped");

		repeat (3) issueRandom(1'b1); // Last two still in flight when reset hits
		@(posedge clk);
		#2;
		reset = 1'b1;
		inValid = 1'b0;
		@(posedge clk);
		#2;
		expectQ.delete();
		dueQ.delete();
		repeat (8) @(posedge clk);
		#2;
		reset = 1'b0;
		repeat (10) driveCycle(1'b0, '0, '0, fpAddSubPkg::opAdd); // Must stay quiet
		issueOp(16'h3C00, 16'h4000, fpAddSubPkg::opAdd);
		issueOp(16'h4400, 16'h3C00, fpAddSubPkg::opSub);
		issueOp(16'hBC00, 16'h3800, fpAddSubPkg::opAdd);
		issueOp(16'h7C00, 16'h4000, fpAddSubPkg::opSub);
		finishTest("reset");

		$display("Checks passed: %0d, failed: %0d", passCount, failCount);
		if (failCount == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
design/fpAddSubPkg.sv
design/fpAddSubPrealign.sv
design/fpAddSubAlign.sv
design/fpAddSubShift.sv
design/fpAddSubExecute.sv
design/fpAddSubNormalize.sv
design/fpAddSubRound.sv
design/fpAddSub.sv
verification/fpAddSubTb.sv

//--- Bender.yml
package:
  name: fpAddSub

sources:
  - design/fpAddSubPkg.sv
  - design/fpAddSubPrealign.sv
  - design/fpAddSubAlign.sv
  - design/fpAddSubShift.sv
  - design/fpAddSubExecute.sv
  - design/fpAddSubNormalize.sv
  - design/fpAddSubRound.sv
  - design/fpAddSub.sv
  - target: test
    files:
      - verification/fpAddSubTb.sv
